/* udma_pkg.sv */
/*
 * Shared sizes, APB register map and configuration bits of the uDMA channel.
 * Imported by every design unit that needs widths, offsets or payload types.
 */
package udma_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int L2_AW          = 12;   // Byte address into L2
    localparam int L2_DEPTH       = 4096; // 4 KB of L2
    localparam int TRANS_W        = 16;   // Transfer size and bytes left
    localparam int WORD_W         = 32;   // Stream word
    localparam int BYTES_PER_WORD = 4;

    localparam int APB_AW = 5;
    localparam int APB_DW = 32;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////
    localparam logic [APB_AW-1:0] REG_RX_SADDR = 5'h00;
    localparam logic [APB_AW-1:0] REG_RX_SIZE  = 5'h04;
    localparam logic [APB_AW-1:0] REG_RX_CFG   = 5'h08;
    localparam logic [APB_AW-1:0] REG_TX_SADDR = 5'h0C;
    localparam logic [APB_AW-1:0] REG_TX_SIZE  = 5'h10;
    localparam logic [APB_AW-1:0] REG_TX_CFG   = 5'h14;
    localparam logic [APB_AW-1:0] REG_STATUS   = 5'h18; // Last mapped offset

    // Enable on write, busy on read
    localparam int CFG_EN_BIT = 4;

    //////////////////////////////////////////////////
    // Payload types
    //////////////////////////////////////////////////
    typedef logic [L2_AW-1:0]   l2_addr_t;
    typedef logic [TRANS_W-1:0] trans_size_t;
    typedef logic [WORD_W-1:0]  word_t;

endpackage

/* udma_if.sv */
/*
 * Internal bundles of the uDMA channel. chan_cfg_if links the register block
 * to one engine, mem_port_if links an engine to one port of the L2 memory.
 */
`timescale 1ns/10ps

interface chan_cfg_if import udma_pkg::*; ();

    l2_addr_t    start_addr; // Programmed L2 start address
    trans_size_t size;       // Programmed transfer size in bytes
    logic        start;      // One-cycle kick
    logic        busy;
    trans_size_t bytes_left; // Live count from the engine

    modport regs (
        output start_addr,
        output size,
        output start,
        input  busy,
        input  bytes_left
    );

    modport engine (
        input  start_addr,
        input  size,
        input  start,
        output busy,
        output bytes_left
    );

endinterface

interface mem_port_if import udma_pkg::*; ();

    l2_addr_t                  addr;
    word_t                     wdata;
    logic [BYTES_PER_WORD-1:0] be;    // Byte lanes taking part in the access
    logic                      we;
    word_t                     rdata; // Little endian, valid one cycle after addr

    modport requester (output addr, output wdata, output be, output we, input rdata);

    modport memory (input addr, input wdata, input be, input we, output rdata);

endinterface

/* l2_byte_mem.sv */
/*
 * 4 KB byte-wide L2 model. Registered little-endian word read on rd,
 * byte-enabled word write on wr, addresses wrap at the end of the array.
 */
`timescale 1ns/10ps

module l2_byte_mem import udma_pkg::*; (
    input  logic       sys_clk,
    mem_port_if.memory rd,
    mem_port_if.memory wr
);

    logic [7:0] mem [L2_DEPTH];

    // Lanes with be set are refreshed, the rest hold their last value
    always_ff @(posedge sys_clk) begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (!rd.we && rd.be[i]) begin
                rd.rdata[8*i +: 8] <= mem[rd.addr + l2_addr_t'(i)];
            end
            if (wr.we && wr.be[i]) begin
                mem[wr.addr + l2_addr_t'(i)] <= wr.wdata[8*i +: 8];
            end
        end
    end

    assign wr.rdata = '0; // Write port returns no data

endmodule

/* udma_cfg_regs.sv */
/*
 * APB register block for the RX and TX channels. Holds start address and
 * size per channel, raises the start pulse and returns live status on read.
 */
`timescale 1ns/10ps

module udma_cfg_regs import udma_pkg::*; (
    input  logic              sys_clk,
    input  logic              rst_n,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    chan_cfg_if.regs          tx_cfg,
    chan_cfg_if.regs          rx_cfg
);

    l2_addr_t    rx_saddr_q;
    trans_size_t rx_size_q;
    logic        rx_start_q;
    l2_addr_t    tx_saddr_q;
    trans_size_t tx_size_q;
    logic        tx_start_q;
    logic        access;
    logic        wr_en;
    logic        addr_ok;

    // A kick needs the enable bit, a nonzero size and an idle channel
    function automatic logic start_ok(input logic [APB_DW-1:0] wdata,
                                      input trans_size_t       size,
                                      input logic              busy);
        return wdata[CFG_EN_BIT] && (size != '0) && !busy;
    endfunction

    assign access   = psel_i & penable_i; // Second APB phase
    assign wr_en    = access & pwrite_i;
    assign pready_o = 1'b1;               // No wait states

    //////////////////////////////////////////////////
    // Register writes and start pulses
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_saddr_q <= '0;
            rx_size_q  <= '0;
            rx_start_q <= 1'b0;
            tx_saddr_q <= '0;
            tx_size_q  <= '0;
            tx_start_q <= 1'b0;
        end else begin
            rx_start_q <= 1'b0;
            tx_start_q <= 1'b0;
            if (wr_en) begin
                case (paddr_i)
                    REG_RX_SADDR: rx_saddr_q <= pwdata_i[L2_AW-1:0];
                    REG_RX_SIZE:  rx_size_q  <= pwdata_i[TRANS_W-1:0];
                    REG_RX_CFG:   rx_start_q <= start_ok(pwdata_i, rx_size_q, rx_cfg.busy);
                    REG_TX_SADDR: tx_saddr_q <= pwdata_i[L2_AW-1:0];
                    REG_TX_SIZE:  tx_size_q  <= pwdata_i[TRANS_W-1:0];
                    REG_TX_CFG:   tx_start_q <= start_ok(pwdata_i, tx_size_q, tx_cfg.busy);
                    default: ; // STATUS is read only
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Readback and decode error
    //////////////////////////////////////////////////
    always_comb begin
        addr_ok  = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            REG_RX_SADDR: prdata_o = APB_DW'(rx_saddr_q);
            REG_RX_SIZE:  prdata_o = APB_DW'(rx_cfg.busy ? rx_cfg.bytes_left : rx_size_q);
            REG_RX_CFG:   prdata_o[CFG_EN_BIT] = rx_cfg.busy;
            REG_TX_SADDR: prdata_o = APB_DW'(tx_saddr_q);
            REG_TX_SIZE:  prdata_o = APB_DW'(tx_cfg.busy ? tx_cfg.bytes_left : tx_size_q);
            REG_TX_CFG:   prdata_o[CFG_EN_BIT] = tx_cfg.busy;
            REG_STATUS:   prdata_o = APB_DW'({rx_cfg.busy, tx_cfg.busy});
            default:      addr_ok = 1'b0; // Unaligned or past STATUS
        endcase
    end

    assign pslverr_o = access & ~addr_ok;

    assign rx_cfg.start_addr = rx_saddr_q;
    assign rx_cfg.size       = rx_size_q;
    assign rx_cfg.start      = rx_start_q;
    assign tx_cfg.start_addr = tx_saddr_q;
    assign tx_cfg.size       = tx_size_q;
    assign tx_cfg.start      = tx_start_q;

endmodule

/* udma_tx_streamer.sv */
/*
 * TX engine. Reads one L2 word at a time and offers it on the outgoing
 * valid/ready stream until the programmed byte count is used up.
 */
`timescale 1ns/10ps

module udma_tx_streamer import udma_pkg::*; (
    input  logic         sys_clk,
    input  logic         rst_n,
    chan_cfg_if.engine   cfg,
    mem_port_if.requester rd,
    output word_t        tx_data_o,
    output logic         tx_valid_o,
    input  logic         tx_ready_i,
    output logic         eot_o
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_READ,  // Address on the L2 read port
        TX_VALID  // Word offered, waiting for ready
    } tx_state_e;

    tx_state_e   state_q;
    l2_addr_t    addr_q;
    trans_size_t left_q;
    logic        last_word;

    assign last_word = (left_q <= TRANS_W'(BYTES_PER_WORD));

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= TX_IDLE;
            addr_q  <= '0;
            left_q  <= '0;
            eot_o   <= 1'b0;
        end else begin
            eot_o <= 1'b0;
            case (state_q)
                TX_IDLE: begin
                    if (cfg.start) begin
                        addr_q  <= cfg.start_addr;
                        left_q  <= cfg.size;
                        state_q <= TX_READ;
                    end
                end
                TX_READ: state_q <= TX_VALID; // Data lands in rdata this edge
                TX_VALID: begin
                    if (tx_ready_i) begin
                        addr_q  <= addr_q + L2_AW'(BYTES_PER_WORD); // Wraps in 4 KB
                        left_q  <= last_word ? '0 : left_q - TRANS_W'(BYTES_PER_WORD);
                        state_q <= last_word ? TX_IDLE : TX_READ;
                        eot_o   <= last_word;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // The memory only updates rdata on a read, so the word holds under stall
    assign rd.addr  = addr_q;
    assign rd.be    = (state_q == TX_READ) ? '1 : '0;
    assign rd.we    = 1'b0;
    assign rd.wdata = '0;

    assign tx_data_o  = rd.rdata;
    assign tx_valid_o = (state_q == TX_VALID);

    assign cfg.busy       = (state_q != TX_IDLE);
    assign cfg.bytes_left = left_q;

endmodule

/* udma_rx_writer.sv */
/*
 * RX engine. Accepts stream words while busy and writes them into L2,
 * trimming the byte enables on a partial last word.
 */
`timescale 1ns/10ps

module udma_rx_writer import udma_pkg::*; (
    input  logic          sys_clk,
    input  logic          rst_n,
    chan_cfg_if.engine    cfg,
    mem_port_if.requester wr,
    input  word_t         rx_data_i,
    input  logic          rx_valid_i,
    output logic          rx_ready_o,
    output logic          eot_o
);

    logic                      busy_q;
    l2_addr_t                  addr_q;
    trans_size_t               left_q;
    logic                      last_word;
    logic                      accept;
    logic [BYTES_PER_WORD-1:0] lane_en;

    assign last_word = (left_q <= TRANS_W'(BYTES_PER_WORD));
    assign accept    = busy_q & rx_valid_i;

    // Low lanes only when fewer than four bytes remain
    always_comb begin
        if (left_q >= TRANS_W'(BYTES_PER_WORD)) begin
            lane_en = '1;
        end else begin
            lane_en = ~({BYTES_PER_WORD{1'b1}} << left_q[1:0]);
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            addr_q <= '0;
            left_q <= '0;
            eot_o  <= 1'b0;
        end else begin
            eot_o <= 1'b0;
            if (!busy_q && cfg.start) begin
                busy_q <= 1'b1;
                addr_q <= cfg.start_addr;
                left_q <= cfg.size;
            end else if (accept) begin
                addr_q <= addr_q + L2_AW'(BYTES_PER_WORD); // Wraps in 4 KB
                left_q <= last_word ? '0 : left_q - TRANS_W'(BYTES_PER_WORD);
                busy_q <= ~last_word;
                eot_o  <= last_word;
            end
        end
    end

    assign wr.addr  = addr_q;
    assign wr.wdata = rx_data_i;
    assign wr.we    = accept;
    assign wr.be    = accept ? lane_en : '0;

    assign rx_ready_o     = busy_q;
    assign cfg.busy       = busy_q;
    assign cfg.bytes_left = left_q;

endmodule

/* udma_channel_top.sv */
/*
 * Top of the uDMA channel: APB register block, TX streamer, RX writer and
 * the shared L2 memory, with one end-of-transfer event for both directions.
 */
`timescale 1ns/10ps

module udma_channel_top import udma_pkg::*; (
    input  logic              sys_clk,
    input  logic              rst_n,
    // APB slave
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    // TX stream out
    output word_t             tx_data_o,
    output logic              tx_valid_o,
    input  logic              tx_ready_i,
    // RX stream in
    input  word_t             rx_data_i,
    input  logic              rx_valid_i,
    output logic              rx_ready_o,
    output logic              evt_eot_o
);

    logic tx_eot;
    logic rx_eot;

    chan_cfg_if tx_cfg_if ();
    chan_cfg_if rx_cfg_if ();
    mem_port_if rd_port ();
    mem_port_if wr_port ();

    //////////////////////////////////////////////////
    // Configuration
    //////////////////////////////////////////////////
    udma_cfg_regs u_cfg_regs (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .tx_cfg    (tx_cfg_if),
        .rx_cfg    (rx_cfg_if)
    );

    //////////////////////////////////////////////////
    // Engines and L2
    //////////////////////////////////////////////////
    udma_tx_streamer u_tx_streamer (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .cfg        (tx_cfg_if),
        .rd         (rd_port),
        .tx_data_o  (tx_data_o),
        .tx_valid_o (tx_valid_o),
        .tx_ready_i (tx_ready_i),
        .eot_o      (tx_eot)
    );

    udma_rx_writer u_rx_writer (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .cfg        (rx_cfg_if),
        .wr         (wr_port),
        .rx_data_i  (rx_data_i),
        .rx_valid_i (rx_valid_i),
        .rx_ready_o (rx_ready_o),
        .eot_o      (rx_eot)
    );

    l2_byte_mem u_l2_mem (
        .sys_clk (sys_clk),
        .rd      (rd_port),
        .wr      (wr_port)
    );

    assign evt_eot_o = tx_eot | rx_eot; // Same-cycle ends merge into one pulse

endmodule

/* udma_checker.sv */
/*
 * Scoreboard of the testbench. Keeps a byte model of L2 from RX traffic,
 * checks TX words and end events, and takes register checks from the test.
 */
`timescale 1ns/10ps

module udma_checker import udma_pkg::*; (
    input  logic              sys_clk,
    input  logic              rst_n,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    input  logic              pready_i,
    input  word_t             tx_data_i,
    input  logic              tx_valid_i,
    input  logic              tx_ready_i,
    input  word_t             rx_data_i,
    input  logic              rx_valid_i,
    input  logic              rx_ready_i,
    input  logic              evt_eot_i,
    output int                err_cnt_o,
    output int                test_cnt_o
);

    logic [7:0]  model [L2_DEPTH];
    l2_addr_t    rx_saddr, rx_addr, tx_saddr, tx_addr;
    trans_size_t rx_size, rx_left, tx_size, tx_left;
    logic        rx_act, tx_act, eot_pend;
    word_t       exp_word;
    string       cur_name = "reset";
    int          test_errs;

    initial begin
        err_cnt_o  = 0;
        test_cnt_o = 0;
        test_errs  = 0;
    end

    task automatic begin_test(input string name);
        cur_name  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        test_cnt_o++;
        $display("%-8s %s", cur_name, (test_errs == 0) ? "ok" : "failed");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s %s expected %0h actual %0h", cur_name, what, exp, act);
            err_cnt_o++;
            test_errs++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s: %s", cur_name, msg);
        err_cnt_o++;
        test_errs++;
    endtask

    task automatic report_counts();
        $display("tests %0d, errors %0d", test_cnt_o, err_cnt_o);
    endtask

    //////////////////////////////////////////////////
    // Cycle model of both channels
    //////////////////////////////////////////////////
    always @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_act   = 1'b0;
            tx_act   = 1'b0;
            eot_pend = 1'b0;
            rx_size  = '0;
            tx_size  = '0;
        end else begin
            if (evt_eot_i !== eot_pend) begin
                note_failure(eot_pend ? "evt_eot missing after last word" : "unexpected evt_eot");
            end
            eot_pend = 1'b0;
            if (psel_i && penable_i && pready_i !== 1'b1) begin
                note_failure("pready low in an access cycle");
            end
            if (psel_i && penable_i && pwrite_i) begin
                case (paddr_i)
                    REG_RX_SADDR: rx_saddr = pwdata_i[L2_AW-1:0];
                    REG_RX_SIZE:  rx_size  = pwdata_i[TRANS_W-1:0];
                    REG_TX_SADDR: tx_saddr = pwdata_i[L2_AW-1:0];
                    REG_TX_SIZE:  tx_size  = pwdata_i[TRANS_W-1:0];
                    REG_RX_CFG: if (pwdata_i[CFG_EN_BIT] && rx_size != 0 && !rx_act) begin
                        rx_act  = 1'b1;
                        rx_addr = rx_saddr;
                        rx_left = rx_size;
                    end
                    REG_TX_CFG: if (pwdata_i[CFG_EN_BIT] && tx_size != 0 && !tx_act) begin
                        tx_act  = 1'b1;
                        tx_addr = tx_saddr;
                        tx_left = tx_size;
                    end
                    default: ;
                endcase
            end
            if (rx_valid_i && rx_ready_i) begin
                if (!rx_act) note_failure("RX took a word while idle");
                for (int i = 0; i < BYTES_PER_WORD; i++) begin
                    if (rx_left > trans_size_t'(i)) model[rx_addr + l2_addr_t'(i)] = rx_data_i[8*i +: 8];
                end
                rx_addr = rx_addr + l2_addr_t'(BYTES_PER_WORD); // 4 KB wrap
                if (rx_left <= trans_size_t'(BYTES_PER_WORD)) begin
                    rx_left  = '0;
                    rx_act   = 1'b0;
                    eot_pend = 1'b1;
                end else begin
                    rx_left = rx_left - trans_size_t'(BYTES_PER_WORD);
                end
            end
            if (tx_valid_i && tx_ready_i) begin
                if (!tx_act) note_failure("TX sent a word while idle");
                for (int i = 0; i < BYTES_PER_WORD; i++) begin
                    exp_word[8*i +: 8] = model[tx_addr + l2_addr_t'(i)];
                end
                check_value($sformatf("tx word @%0h", tx_addr), exp_word, tx_data_i);
                tx_addr = tx_addr + l2_addr_t'(BYTES_PER_WORD);
                if (tx_left <= trans_size_t'(BYTES_PER_WORD)) begin
                    tx_left  = '0;
                    tx_act   = 1'b0;
                    eot_pend = 1'b1;
                end else begin
                    tx_left = tx_left - trans_size_t'(BYTES_PER_WORD);
                end
            end
        end
    end

endmodule

/* udma_assertions.sv */
/*
 * Protocol assertions bound to the channel top level.
 * Covers TX stall stability, the single-cycle event and pslverr timing.
 */
`timescale 1ns/10ps

module udma_assertions import udma_pkg::*; (
    input logic              sys_clk,
    input logic              rst_n,
    input logic              psel_i,
    input logic              penable_i,
    input logic [APB_AW-1:0] paddr_i,
    input logic              pslverr_o,
    input word_t             tx_data_o,
    input logic              tx_valid_o,
    input logic              tx_ready_i,
    input logic              evt_eot_o
);

    logic mapped;

    assign mapped = paddr_i inside {REG_RX_SADDR, REG_RX_SIZE, REG_RX_CFG,
                                    REG_TX_SADDR, REG_TX_SIZE, REG_TX_CFG, REG_STATUS};

    tx_hold_stable: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
        else $error("tx_valid or tx_data changed during a stall");

    eot_one_cycle: assert property (@(posedge sys_clk) disable iff (!rst_n)
        evt_eot_o |=> !evt_eot_o)
        else $error("evt_eot longer than one cycle");

    slverr_in_access: assert property (@(posedge sys_clk) disable iff (!rst_n)
        pslverr_o == (psel_i && penable_i && !mapped))
        else $error("pslverr outside an access cycle or on a mapped offset");

endmodule

bind udma_channel_top udma_assertions u_assertions (.*);

/* tb_udma.sv */
/*
 * Testbench top for the uDMA channel. Reads tests from udma_vectors.txt,
 * drives APB and both streams, and leaves the comparing to udma_checker.
 */
`timescale 1ns/10ps

module tb_udma import udma_pkg::*;;

    localparam int TIMEOUT = 2000; // Cycles per wait

    logic              sys_clk, rst_n;
    logic              psel_i, penable_i, pwrite_i;
    logic [APB_AW-1:0] paddr_i;
    logic [APB_DW-1:0] pwdata_i, prdata_o;
    logic              pready_o, pslverr_o;
    word_t             tx_data_o, rx_data_i;
    logic              tx_valid_o, tx_ready_i, rx_valid_i, rx_ready_o, evt_eot_o;
    int                err_cnt, test_cnt;
    int                tx_accepts; // TX handshakes since reset

    udma_channel_top dut0 (.*);

    udma_checker chk0 (
        .sys_clk(sys_clk), .rst_n(rst_n), .psel_i(psel_i), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i), .pready_i(pready_o),
        .tx_data_i(tx_data_o), .tx_valid_i(tx_valid_o), .tx_ready_i(tx_ready_i),
        .rx_data_i(rx_data_i), .rx_valid_i(rx_valid_i), .rx_ready_i(rx_ready_o),
        .evt_eot_i(evt_eot_o), .err_cnt_o(err_cnt), .test_cnt_o(test_cnt)
    );

    always #5 sys_clk = ~sys_clk;

    // Random TX back-pressure, roughly one stall in four
    always @(posedge sys_clk) begin
        if (rst_n) tx_ready_i <= ($urandom % 4) != 0;
    end

    always @(posedge sys_clk) begin
        if (rst_n && tx_valid_o && tx_ready_i) tx_accepts++;
    end

    //////////////////////////////////////////////////
    // Bus and stream tasks
    //////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata,
                              output logic [APB_DW-1:0] rdata, output logic err);
        @(posedge sys_clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge sys_clk);
        penable_i <= 1'b1;
        @(negedge sys_clk); // Sample mid access cycle
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge sys_clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        logic [APB_DW-1:0] rd;
        logic              err;
        apb_access(1'b1, addr, data, rd, err);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic send_rx_words(input int n);
        int sent;
        int cyc;
        sent = 0;
        cyc  = 0;
        @(posedge sys_clk);
        rx_valid_i <= 1'b1;
        rx_data_i  <= $urandom;
        while (sent < n && cyc < TIMEOUT) begin
            @(negedge sys_clk);
            cyc++;
            if (rx_ready_o) sent++; // Taken on the coming edge
            @(posedge sys_clk);
            if (sent == n) rx_valid_i <= 1'b0;
            else if (rx_ready_o) rx_data_i <= $urandom;
        end
        rx_valid_i <= 1'b0;
        if (sent < n) chk0.note_failure("RX words not taken within timeout");
    endtask

    task automatic wait_eot();
        int   cyc;
        logic seen;
        cyc  = 0;
        seen = 1'b0;
        while (!seen && cyc < TIMEOUT) begin
            @(negedge sys_clk);
            cyc++;
            if (evt_eot_o) seen = 1'b1;
        end
        if (!seen) chk0.note_failure("no evt_eot within timeout");
    endtask

    //////////////////////////////////////////////////
    // Test kinds
    //////////////////////////////////////////////////
    task automatic run_load(input int addr, input int size);
        logic [APB_DW-1:0] v;
        apb_write(REG_RX_SADDR, addr);
        apb_write(REG_RX_SIZE, size);
        apb_write(REG_RX_CFG, 32'h10);
        send_rx_words((size + 3) / 4);
        wait_eot();
        apb_read(REG_STATUS, v);
        chk0.check_value("status", 0, v);
        apb_read(REG_RX_SIZE, v);
        chk0.check_value("rx size", size, v);
    endtask

    task automatic run_dump(input int addr, input int size);
        logic [APB_DW-1:0] v;
        int                first;
        first = tx_accepts;
        apb_write(REG_TX_SADDR, addr);
        apb_write(REG_TX_SIZE, size);
        apb_write(REG_TX_CFG, 32'h10);
        apb_read(REG_TX_SIZE, v); // Transfer still running here
        if (v == 0 || v > size || (size - v) % 4 != 0) begin
            chk0.check_value("tx bytes_left", size, v);
        end
        wait_eot();
        chk0.check_value("tx word count", (size + 3) / 4, tx_accepts - first);
        apb_read(REG_STATUS, v);
        chk0.check_value("status", 0, v);
        apb_read(REG_TX_SIZE, v);
        chk0.check_value("tx size", size, v);
    endtask

    task automatic run_stat(input int addr, input int size);
        logic [APB_DW-1:0] v;
        apb_write(REG_TX_SIZE, 0);
        apb_write(REG_TX_CFG, 32'h10); // Size 0, must not start
        repeat (4) @(posedge sys_clk);
        apb_read(REG_STATUS, v);
        chk0.check_value("status after size 0", 0, v);
        apb_write(REG_RX_SADDR, addr);
        apb_write(REG_RX_SIZE, size);
        apb_write(REG_RX_CFG, 32'h10);
        apb_read(REG_STATUS, v);
        chk0.check_value("status rx busy", 2, v);
        apb_write(REG_RX_CFG, 32'h10); // Busy, ignored
        apb_read(REG_STATUS, v);
        chk0.check_value("status after busy start", 2, v);
        send_rx_words(1);
        apb_read(REG_RX_SIZE, v); // One word in, transfer still running
        chk0.check_value("rx bytes_left", size - 4, v);
        send_rx_words((size + 3) / 4 - 1);
        wait_eot();
        apb_read(REG_STATUS, v);
        chk0.check_value("status idle", 0, v);
    endtask

    task automatic run_badr();
        logic [APB_DW-1:0] v;
        logic              err;
        apb_access(1'b0, 5'h1C, '0, v, err);
        chk0.check_value("pslverr read 1c", 1, err);
        apb_access(1'b1, 5'h1F, 32'h10, v, err);
        chk0.check_value("pslverr write 1f", 1, err);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int    fd;
        int    addr;
        int    size;
        string line, name, kind;
        void'($urandom(48));
        sys_clk = 0;
        rst_n = 0;
        tx_accepts = 0;
        {psel_i, penable_i, pwrite_i, tx_ready_i, rx_valid_i} = '0;
        paddr_i = '0;
        pwdata_i = '0;
        rx_data_i = '0;
        repeat (8) @(posedge sys_clk);
        rst_n <= 1'b1;
        fd = $fopen("udma_vectors.txt", "r");
        if (fd == 0) chk0.note_failure("cannot open udma_vectors.txt");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%s %s %h %d", name, kind, addr, size));
            chk0.begin_test(name);
            if (kind == "LOAD") run_load(addr, size);
            else if (kind == "DUMP") run_dump(addr, size);
            else if (kind == "STAT") run_stat(addr, size);
            else if (kind == "BADR") run_badr();
            else chk0.note_failure({"unknown test kind ", kind});
            chk0.end_test();
        end
        if (fd != 0) $fclose(fd);
        repeat (4) @(posedge sys_clk);
        chk0.report_counts();
        if (err_cnt == 0 && test_cnt > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* all.f */
udma_pkg.sv
udma_if.sv
l2_byte_mem.sv
udma_cfg_regs.sv
udma_tx_streamer.sv
udma_rx_writer.sv
udma_channel_top.sv
udma_checker.sv
udma_assertions.sv
tb_udma.sv

/* Makefile */
# Verilator build and run of the uDMA channel testbench

OBJ = obj_dir

all: run

compile:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_udma -Mdir $(OBJ) -o vtb

run: compile
	./$(OBJ)/vtb | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all compile run clean

/* udma_vectors.txt */
# columns: name kind l2_addr(hex) size(bytes, decimal)
# LOAD = RX into L2, DUMP = TX out of L2, STAT = start rules, BADR = unmapped offset
load_a   LOAD 100 64
dump_a   DUMP 100 64
load_p   LOAD 100 7
dump_p   DUMP 100 16
load_w   LOAD FF8 16
dump_w   DUMP FF8 16
stat_i   STAT 200 12
dump_s   DUMP 200 12
bad_off  BADR 000 0
load_o   LOAD 300 13
dump_o   DUMP 300 12
load_b   LOAD 800 40
dump_b   DUMP 800 40
